// ==== l2_golden.txt ====
// columns: op address write_data expected, all hex
// op 0 read, 1 read hit 2 cycles, 2 write, 3 write hit 2 cycles, 4 idle, 5 mem word, 6 mem writes, f end
0 00000004 00000000 5a5a0004
1 00000004 00000000 5a5a0004
3 00000004 11111111 00000000
1 00000004 00000000 11111111
2 00000044 22222222 00000000
1 00000044 00000000 22222222
0 0000000c 00000000 5a5a000c
0 0000004c 00000000 5a5a004c
0 0000008c 00000000 5a5a008c
0 000000cc 00000000 5a5a00cc
6 00000000 00000000 00000000
0 0000010c 00000000 5a5a010c
6 00000000 00000000 00000000
1 0000010c 00000000 5a5a010c
2 00000014 aaaa0001 00000000
2 00000054 aaaa0002 00000000
2 00000094 aaaa0003 00000000
2 000000d4 aaaa0004 00000000
0 00000114 00000000 5a5a0114
2 00000014 bbbb0001 00000000
0 00000154 00000000 5a5a0154
0 00000014 00000000 bbbb0001
2 00000094 bbbb0003 00000000
0 00000194 00000000 5a5a0194
0 000001d4 00000000 5a5a01d4
0 00000054 00000000 aaaa0002
0 000000d4 00000000 aaaa0004
0 00000094 00000000 bbbb0003
0 00000214 00000000 5a5a0214
0 00000254 00000000 5a5a0254
0 00000294 00000000 5a5a0294
0 000002d4 00000000 5a5a02d4
4 00000190 00000000 00000000
5 00000014 00000000 bbbb0001
5 00000054 00000000 aaaa0002
5 00000094 00000000 bbbb0003
5 000000d4 00000000 aaaa0004
f 00000000 00000000 00000000

// ==== run.sh ====
#!/bin/sh
# build and run the l2_cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
if ! verilator --binary --timing --timescale 1ns/1ps \
        --top-module tb_l2_cache -f vlog.f -o tb_l2_cache; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_l2_cache > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

# verdict comes from the log
if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== vlog.f ====
cache_geom_pkg.sv
cache_ctrl_pkg.sv
plru_tree.sv
cache_ways.sv
eviction_buffer.sv
mem_arbiter.sv
cache_control.sv
l2_cache.sv
tb_l2_cache.sv

// ==== tb_l2_cache.sv ====
module tb_l2_cache;

    timeunit 1ns;
    timeprecision 1ps;

    import cache_geom_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_OPS      = 64;
    localparam int XFER_LIMIT   = 500;
    localparam int HIT_LATENCY  = 2;
    localparam logic [31:0] MEM_PATTERN = 32'h5a5a0000;

    // op codes in the first column of the golden file
    localparam logic [31:0] OP_READ     = 32'h0;
    localparam logic [31:0] OP_READ_HIT = 32'h1;
    localparam logic [31:0] OP_WRITE    = 32'h2;
    localparam logic [31:0] OP_WRITE_HIT = 32'h3;
    localparam logic [31:0] OP_IDLE     = 32'h4;
    localparam logic [31:0] OP_MEM_WORD = 32'h5;
    localparam logic [31:0] OP_MEM_WRITES = 32'h6;
    localparam logic [31:0] OP_END      = 32'hf;

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              mem_psel;
    logic              mem_penable;
    logic              mem_pwrite;
    logic [ADDR_W-1:0] mem_paddr;
    logic [DATA_W-1:0] mem_pwdata;
    logic [DATA_W-1:0] mem_prdata;
    logic              mem_pready;

    // four words per line: op, address, write data, expected
    logic [31:0] golden [MAX_OPS*4];

    // sparse backing memory
    logic [31:0] mem_words [logic [31:0]];
    int          mem_write_count;
    logic [31:0] rng_state;

    int data_errors;
    int latency_errors;
    int mem_errors;

    l2_cache i_l2_cache (.*);

    initial
    begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 32-bit xorshift step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // unwritten words read back as their address xor the pattern
    function automatic logic [31:0] mem_read_word(input logic [31:0] a);
        if (mem_words.exists(a))
            return mem_words[a];
        return a ^ MEM_PATTERN;
    endfunction

    // APB slave, 0 to 3 wait states per transfer
    initial
    begin : memory_model
        logic [1:0]  wait_cycles;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        is_write;
        mem_pready      = 1'b0;
        mem_prdata      = '0;
        mem_write_count = 0;
        rng_state       = 32'hca903991;
        forever
        begin
            // setup phase seen mid-cycle, address already stable
            @(negedge clk);
            if (!rst && mem_psel && !mem_penable)
            begin
                addr        = mem_paddr;
                wdata       = mem_pwdata;
                is_write    = mem_pwrite;
                rng_state   = next_random(rng_state);
                wait_cycles = rng_state[1:0];
                @(posedge clk);
                repeat (wait_cycles) @(posedge clk);
                mem_pready <= 1'b1;
                mem_prdata <= mem_read_word(addr);
                @(posedge clk);
                mem_pready <= 1'b0;
                if (is_write)
                begin
                    mem_words[addr] = wdata;
                    mem_write_count++;
                end
            end
        end
    end

    // one CPU APB transfer, latency counted from the first access cycle
    task automatic cpu_transfer(
        input  logic        write,
        input  logic [31:0] addr,
        input  logic [31:0] wdata,
        output logic [31:0] rdata,
        output int          latency,
        output logic        timed_out
    );
        latency = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && latency < XFER_LIMIT)
        begin
            @(negedge clk);
            latency++;
        end
        timed_out = !pready;
        rdata     = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    initial
    begin : stimulus
        int          op_idx;
        int          base;
        int          latency;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic [31:0] rdata;
        logic        hung;
        rst            = 1'b1;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        data_errors    = 0;
        latency_errors = 0;
        mem_errors     = 0;
        hung           = 1'b0;
        op_idx         = 0;
        for (int i = 0; i < MAX_OPS * 4; i++)
            golden[i] = OP_END;
        $readmemh("l2_golden.txt", golden);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        while (!hung && op_idx < MAX_OPS && golden[op_idx*4] != OP_END)
        begin
            base     = op_idx * 4;
            op       = golden[base];
            addr     = golden[base+1];
            wdata    = golden[base+2];
            exp_data = golden[base+3];
            case (op)
                OP_READ, OP_READ_HIT, OP_WRITE, OP_WRITE_HIT:
                begin
                    cpu_transfer(op == OP_WRITE || op == OP_WRITE_HIT, addr, wdata,
                                 rdata, latency, hung);
                    if (hung)
                        $display("timeout: cache gave no pready for op %0d at %08h",
                                 op_idx, addr);
                    else if ((op == OP_READ || op == OP_READ_HIT) && rdata != exp_data)
                    begin
                        $display("ERROR %0t: read %08h returned %08h, expected %08h",
                                 $time, addr, rdata, exp_data);
                        data_errors++;
                    end
                    // hits finish two cycles into the access phase
                    if (!hung && (op == OP_READ_HIT || op == OP_WRITE_HIT) &&
                        latency != HIT_LATENCY)
                    begin
                        $display("ERROR %0t: hit at %08h took %0d cycles, expected %0d",
                                 $time, addr, latency, HIT_LATENCY);
                        latency_errors++;
                    end
                end
                OP_IDLE:
                    repeat (int'(addr)) @(posedge clk);
                OP_MEM_WORD:
                    if (mem_read_word(addr) != exp_data)
                    begin
                        $display("ERROR %0t: memory %08h holds %08h, expected %08h",
                                 $time, addr, mem_read_word(addr), exp_data);
                        mem_errors++;
                    end
                OP_MEM_WRITES:
                    if (mem_write_count != int'(exp_data))
                    begin
                        $display("ERROR %0t: %0d memory writes seen, expected %0d",
                                 $time, mem_write_count, exp_data);
                        mem_errors++;
                    end
                default:
                begin
                    $display("golden file line %0d has an unknown op code %0h", op_idx, op);
                    data_errors++;
                end
            endcase
            op_idx++;
        end

        $display("errors: data %0d, latency %0d, memory %0d, timeouts %0d",
                 data_errors, latency_errors, mem_errors, hung);
        if (data_errors == 0 && latency_errors == 0 && mem_errors == 0 && !hung)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== l2_cache.sv ====
module l2_cache (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [cache_geom_pkg::ADDR_W-1:0] paddr,
    input  logic [cache_geom_pkg::DATA_W-1:0] pwdata,
    output logic [cache_geom_pkg::DATA_W-1:0] prdata,
    output logic                              pready,
    output logic                              mem_psel,
    output logic                              mem_penable,
    output logic                              mem_pwrite,
    output logic [cache_geom_pkg::ADDR_W-1:0] mem_paddr,
    output logic [cache_geom_pkg::DATA_W-1:0] mem_pwdata,
    input  logic [cache_geom_pkg::DATA_W-1:0] mem_prdata,
    input  logic                              mem_pready
);

    import cache_geom_pkg::*;

    // controller to arrays and tree
    logic [ADDR_W-1:0]   lookup_addr;
    logic                fill_load;
    logic [WAY_W-1:0]    fill_way;
    logic                write_load;
    logic                inval_load;
    logic                plru_touch;
    logic [WAY_W-1:0]    touch_way;
    logic                hit;
    logic [WAY_W-1:0]    hit_way;
    logic [DATA_W-1:0]   rdata;
    logic [NUM_WAYS-1:0] valid_vec;
    logic                victim_dirty;
    logic [TAG_W-1:0]    victim_tag;
    logic [WAY_W-1:0]    victim_way;

    // controller and eviction buffer
    logic                evict_push;
    logic [ADDR_W-1:0]   evict_addr;
    logic [DATA_W-1:0]   evict_data;
    logic                merge_write;
    logic                ewb_full;
    logic                ewb_hit;
    logic [DATA_W-1:0]   ewb_rdata;

    // the two memory masters
    logic                fill_req;
    logic [ADDR_W-1:0]   fill_addr;
    logic                fill_done;
    logic [DATA_W-1:0]   fill_rdata;
    logic                drain_req;
    logic [ADDR_W-1:0]   drain_addr;
    logic [DATA_W-1:0]   drain_wdata;
    logic                drain_done;

    cache_control i_cache_control (.*);

    // the evicted way is the one refilled
    cache_ways i_cache_ways (
        .inval_way  (fill_way),
        .fill_data  (fill_rdata),
        .write_data (pwdata),
        .*
    );

    plru_tree i_plru_tree (
        .set_idx (lookup_addr[OFFSET_W +: SET_W]),
        .*
    );

    eviction_buffer i_eviction_buffer (
        .merge_data (pwdata),
        .*
    );

    mem_arbiter i_mem_arbiter (.*);

endmodule

// ==== cache_control.sv ====
module cache_control (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [cache_geom_pkg::ADDR_W-1:0] paddr,
    input  logic [cache_geom_pkg::DATA_W-1:0] pwdata,
    input  logic                              hit,
    input  logic [cache_geom_pkg::WAY_W-1:0]  hit_way,
    input  logic [cache_geom_pkg::DATA_W-1:0] rdata,
    input  logic [cache_geom_pkg::WAY_W-1:0]  victim_way,
    input  logic                              victim_dirty,
    input  logic [cache_geom_pkg::TAG_W-1:0]  victim_tag,
    input  logic                              ewb_hit,
    input  logic [cache_geom_pkg::DATA_W-1:0] ewb_rdata,
    input  logic                              ewb_full,
    input  logic                              fill_done,
    input  logic [cache_geom_pkg::DATA_W-1:0] fill_rdata,
    output logic [cache_geom_pkg::DATA_W-1:0] prdata,
    output logic                              pready,
    output logic [cache_geom_pkg::ADDR_W-1:0] lookup_addr,
    output logic                              fill_req,
    output logic [cache_geom_pkg::ADDR_W-1:0] fill_addr,
    output logic                              fill_load,
    output logic [cache_geom_pkg::WAY_W-1:0]  fill_way,
    output logic                              write_load,
    output logic                              inval_load,
    output logic                              plru_touch,
    output logic [cache_geom_pkg::WAY_W-1:0]  touch_way,
    output logic                              evict_push,
    output logic [cache_geom_pkg::ADDR_W-1:0] evict_addr,
    output logic [cache_geom_pkg::DATA_W-1:0] evict_data,
    output logic                              merge_write
);

    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_t      state;
    ctrl_state_t      next_state;
    logic [WAY_W-1:0] alloc_way;
    logic             in_lookup;
    logic             do_evict;

    // APB holds paddr for the whole transfer
    assign lookup_addr = paddr;
    assign in_lookup   = (state == LOOKUP);
    assign pready      = (state == RESPOND);

    // a hit touches the tree and writes in place
    assign plru_touch  = in_lookup && hit;
    assign touch_way   = hit_way;
    assign write_load  = in_lookup && hit && pwrite;
    // line sits in the buffer instead
    assign merge_write = in_lookup && !hit && ewb_hit && pwrite;

    // victim leaves for the buffer once there is room
    assign do_evict   = (state == EVICT) && !ewb_full;
    assign evict_push = do_evict;
    assign inval_load = do_evict;
    assign evict_addr = {victim_tag, paddr[OFFSET_W +: SET_W], {OFFSET_W{1'b0}}};
    assign evict_data = rdata;

    // word-aligned fill into the way chosen at lookup
    assign fill_req  = (state == FILL);
    assign fill_addr = {paddr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign fill_load = fill_req && fill_done;
    assign fill_way  = alloc_way;

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (psel && penable)
                    next_state = LOOKUP;
            LOOKUP:
                if (hit || ewb_hit)
                    next_state = RESPOND;
                else if (victim_dirty)
                    next_state = EVICT;
                else
                    next_state = FILL;
            EVICT:
                if (!ewb_full)
                    next_state = FILL;
            // look up again after the fill so a write miss then writes as a hit
            FILL:
                if (fill_done)
                    next_state = LOOKUP;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    // writes echo pwdata as the response word
    always_ff @(posedge clk)
    begin
        if (in_lookup)
        begin
            alloc_way <= victim_way;
            if (pwrite)
                prdata <= pwdata;
            else if (hit)
                prdata <= rdata;
            else if (ewb_hit)
                prdata <= ewb_rdata;
        end
    end

endmodule

// ==== mem_arbiter.sv ====
module mem_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fill_req,
    input  logic [cache_geom_pkg::ADDR_W-1:0] fill_addr,
    input  logic                              drain_req,
    input  logic [cache_geom_pkg::ADDR_W-1:0] drain_addr,
    input  logic [cache_geom_pkg::DATA_W-1:0] drain_wdata,
    input  logic                              ewb_full,
    input  logic [cache_geom_pkg::DATA_W-1:0] mem_prdata,
    input  logic                              mem_pready,
    output logic                              fill_done,
    output logic [cache_geom_pkg::DATA_W-1:0] fill_rdata,
    output logic                              drain_done,
    output logic                              mem_psel,
    output logic                              mem_penable,
    output logic                              mem_pwrite,
    output logic [cache_geom_pkg::ADDR_W-1:0] mem_paddr,
    output logic [cache_geom_pkg::DATA_W-1:0] mem_pwdata
);

    import cache_ctrl_pkg::*;

    mem_owner_t owner;
    logic       pick_fill;
    logic       xfer_end;

    // fill first, but a full buffer blocks the controller so it drains first
    assign pick_fill = fill_req && !ewb_full;

    assign mem_psel   = (owner != OWN_NONE);
    assign xfer_end   = mem_penable && mem_pready;
    assign fill_done  = xfer_end && (owner == OWN_FILL);
    assign drain_done = xfer_end && (owner == OWN_DRAIN);
    assign fill_rdata = mem_prdata;

    // grant, setup, access until pready
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            owner       <= OWN_NONE;
            mem_penable <= 1'b0;
        end
        else if (owner == OWN_NONE)
        begin
            if (pick_fill)
                owner <= OWN_FILL;
            else if (drain_req)
                owner <= OWN_DRAIN;
        end
        else if (!mem_penable)
            mem_penable <= 1'b1;
        else if (mem_pready)
        begin
            owner       <= OWN_NONE;
            mem_penable <= 1'b0;
        end
    end

    // address and data frozen at grant, stable through the transfer
    always_ff @(posedge clk)
    begin
        if (owner == OWN_NONE)
        begin
            mem_pwrite <= !pick_fill;
            mem_paddr  <= pick_fill ? fill_addr : drain_addr;
            mem_pwdata <= drain_wdata;
        end
    end

endmodule

// ==== eviction_buffer.sv ====
module eviction_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              evict_push,
    input  logic [cache_geom_pkg::ADDR_W-1:0] evict_addr,
    input  logic [cache_geom_pkg::DATA_W-1:0] evict_data,
    input  logic [cache_geom_pkg::ADDR_W-1:0] lookup_addr,
    input  logic                              merge_write,
    input  logic [cache_geom_pkg::DATA_W-1:0] merge_data,
    input  logic                              drain_done,
    output logic                              ewb_full,
    output logic                              ewb_hit,
    output logic [cache_geom_pkg::DATA_W-1:0] ewb_rdata,
    output logic                              drain_req,
    output logic [cache_geom_pkg::ADDR_W-1:0] drain_addr,
    output logic [cache_geom_pkg::DATA_W-1:0] drain_wdata
);

    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    logic [ADDR_W-1:0]            ent_addr [EWB_DEPTH];
    logic [DATA_W-1:0]            ent_data [EWB_DEPTH];
    logic [EWB_DEPTH-1:0]         ent_valid;
    logic [EWB_DEPTH-1:0]         match;
    logic [$clog2(EWB_DEPTH)-1:0] head;
    logic [$clog2(EWB_DEPTH)-1:0] tail;
    logic [$clog2(EWB_DEPTH)-1:0] hit_idx;
    logic                         head_stale;
    logic                         merge_head;
    logic                         pop;

    // word address match, at most one entry holds a given line
    always_comb
    begin
        hit_idx = '0;
        for (int i = 0; i < EWB_DEPTH; i++)
        begin
            match[i] = ent_valid[i] &&
                       (ent_addr[i][ADDR_W-1:OFFSET_W] == lookup_addr[ADDR_W-1:OFFSET_W]);
            if (match[i])
                hit_idx = i[$bits(hit_idx)-1:0];
        end
    end

    assign ewb_hit   = |match;
    assign ewb_rdata = ent_data[hit_idx];
    assign ewb_full  = &ent_valid;

    // head entry drains whenever it is valid
    assign drain_req   = ent_valid[head];
    assign drain_addr  = ent_addr[head];
    assign drain_wdata = ent_data[head];

    // memory may have taken the old head word, so a merged head drains again
    assign merge_head = merge_write && match[head];
    assign pop        = drain_done && !head_stale && !merge_head;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ent_valid  <= '0;
            head       <= '0;
            tail       <= '0;
            head_stale <= 1'b0;
        end
        else
        begin
            if (evict_push)
            begin
                ent_valid[tail] <= 1'b1;
                tail            <= (tail == EWB_DEPTH - 1) ? '0 : tail + 1'b1;
            end
            if (pop)
            begin
                ent_valid[head] <= 1'b0;
                head            <= (head == EWB_DEPTH - 1) ? '0 : head + 1'b1;
            end
            if (drain_done)
                head_stale <= 1'b0;
            else if (merge_head)
                head_stale <= 1'b1;
        end
    end

    // entry payload, a write hit replaces the word in place
    always_ff @(posedge clk)
    begin
        if (evict_push)
        begin
            ent_addr[tail] <= evict_addr;
            ent_data[tail] <= evict_data;
        end
        if (merge_write && ewb_hit)
            ent_data[hit_idx] <= merge_data;
    end

endmodule

// ==== cache_ways.sv ====
module cache_ways (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [cache_geom_pkg::ADDR_W-1:0]   lookup_addr,
    input  logic                                fill_load,
    input  logic [cache_geom_pkg::WAY_W-1:0]    fill_way,
    input  logic [cache_geom_pkg::DATA_W-1:0]   fill_data,
    input  logic                                write_load,
    input  logic [cache_geom_pkg::DATA_W-1:0]   write_data,
    input  logic                                inval_load,
    input  logic [cache_geom_pkg::WAY_W-1:0]    inval_way,
    input  logic [cache_geom_pkg::WAY_W-1:0]    victim_way,
    output logic                                hit,
    output logic [cache_geom_pkg::WAY_W-1:0]    hit_way,
    output logic [cache_geom_pkg::DATA_W-1:0]   rdata,
    output logic [cache_geom_pkg::NUM_WAYS-1:0] valid_vec,
    output logic                                victim_dirty,
    output logic [cache_geom_pkg::TAG_W-1:0]    victim_tag
);

    import cache_geom_pkg::*;

    logic [TAG_W-1:0]    tag_arr  [NUM_WAYS][NUM_SETS];
    logic [DATA_W-1:0]   data_arr [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_arr [NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_arr [NUM_WAYS];

    logic [SET_W-1:0]    set_idx;
    logic [TAG_W-1:0]    tag;
    logic [NUM_WAYS-1:0] way_hit;
    logic [WAY_W-1:0]    sel_way;

    assign set_idx = lookup_addr[OFFSET_W +: SET_W];
    assign tag     = lookup_addr[ADDR_W-1 -: TAG_W];

    // tag compare in all four ways at once
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            valid_vec[w] = valid_arr[w][set_idx];
            way_hit[w]   = valid_arr[w][set_idx] && (tag_arr[w][set_idx] == tag);
            if (way_hit[w])
                hit_way = WAY_W'(w);
        end
    end

    assign hit = |way_hit;

    // on a miss the read port shows the victim word, used for eviction
    assign sel_way      = hit ? hit_way : victim_way;
    assign rdata        = data_arr[sel_way][set_idx];
    assign victim_dirty = valid_arr[victim_way][set_idx] && dirty_arr[victim_way][set_idx];
    assign victim_tag   = tag_arr[victim_way][set_idx];

    // tag and data payload
    always_ff @(posedge clk)
    begin
        if (fill_load)
        begin
            tag_arr[fill_way][set_idx]  <= tag;
            data_arr[fill_way][set_idx] <= fill_data;
        end
        else if (write_load)
            data_arr[hit_way][set_idx] <= write_data;
    end

    // line state bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                valid_arr[w] <= '0;
                dirty_arr[w] <= '0;
            end
        end
        else
        begin
            if (inval_load)
                valid_arr[inval_way][set_idx] <= 1'b0;
            // fresh fill is clean, a write hit marks the line dirty
            if (fill_load)
            begin
                valid_arr[fill_way][set_idx] <= 1'b1;
                dirty_arr[fill_way][set_idx] <= 1'b0;
            end
            else if (write_load)
                dirty_arr[hit_way][set_idx] <= 1'b1;
        end
    end

endmodule

// ==== plru_tree.sv ====
module plru_tree (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [cache_geom_pkg::SET_W-1:0]    set_idx,
    input  logic                                plru_touch,
    input  logic [cache_geom_pkg::WAY_W-1:0]    touch_way,
    input  logic [cache_geom_pkg::NUM_WAYS-1:0] valid_vec,
    output logic [cache_geom_pkg::WAY_W-1:0]    victim_way
);

    import cache_geom_pkg::*;

    // bit 2 picks the half, bit 1 the pair {0,1}, bit 0 the pair {2,3}
    logic [PLRU_W-1:0] tree [NUM_SETS];
    logic [PLRU_W-1:0] cur;

    assign cur = tree[set_idx];

    // empty ways are used up before the tree is consulted
    always_comb
    begin
        if (!valid_vec[0])
            victim_way = 2'd0;
        else if (!valid_vec[1])
            victim_way = 2'd1;
        else if (!valid_vec[2])
            victim_way = 2'd2;
        else if (!valid_vec[3])
            victim_way = 2'd3;
        // root low, so the victim is in ways 2/3
        else if (!cur[2])
            victim_way = cur[0] ? 2'd2 : 2'd3;
        else
            victim_way = cur[1] ? 2'd0 : 2'd1;
    end

    // point root and leaf away from the way just used
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
                tree[s] <= '0;
        end
        else if (plru_touch)
        begin
            case (touch_way)
                2'd0:    tree[set_idx] <= {1'b0, 1'b0, cur[0]};
                2'd1:    tree[set_idx] <= {1'b0, 1'b1, cur[0]};
                2'd2:    tree[set_idx] <= {1'b1, cur[1], 1'b0};
                default: tree[set_idx] <= {1'b1, cur[1], 1'b1};
            endcase
        end
    end

endmodule

// ==== cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    // cache controller FSM
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        FILL,
        RESPOND
    } ctrl_state_t;

    // current owner of the memory APB bus
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FILL,
        OWN_DRAIN
    } mem_owner_t;

    // eviction write buffer entries
    localparam int EWB_DEPTH = 2;

endpackage

// ==== cache_geom_pkg.sv ====
package cache_geom_pkg;

    // byte address, and one 32-bit word per line
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;

    // 4-way associativity
    localparam int NUM_WAYS = 4;
    localparam int WAY_W    = 2;

    // 16 sets, index sits right above the byte offset
    localparam int NUM_SETS = 16;
    localparam int SET_W    = 4;
    localparam int OFFSET_W = 2;

    // address split is tag | set | offset
    localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;

    // tree pseudo-LRU, one root bit and two leaf bits
    localparam int PLRU_W   = 3;

endpackage
